/* hdl/gl_params.svh */
`ifndef GL_PARAMS_SVH
`define GL_PARAMS_SVH

////////////////////
// program memory
////////////////////

// words of instruction memory
`define GL_PROG_DEPTH 256

// program counter and host address width
`define GL_ADDR_W 8

`endif

/* hdl/gl_pkg.sv */
package gl_pkg;

    // register format opcodes, anything else is a no-op
    typedef enum logic [7:0] {
        OP_SET_COLOR  = 8'h01,
        OP_SET_VIEW_X = 8'h02,
        OP_SET_VIEW_Y = 8'h03,
        OP_VERTEX_X   = 8'h04,
        OP_VERTEX_Y   = 8'h05,   // emits the vertex
        OP_HALT       = 8'hFF
    } gl_opcode_e;

    // command kinds from decode to execute
    typedef enum logic [1:0] {
        CMD_LOAD   = 2'd0,   // one matrix element
        CMD_VERTEX = 2'd1,
        CMD_HALT   = 2'd2    // end of program marker
    } gl_cmd_kind_e;

    ////////////////////
    // instruction word
    ////////////////////

    // bit 31 picks the member, 0 for reg_fmt and 1 for mat_fmt
    typedef union packed {
        struct packed {
            logic        typ;
            logic [22:0] imm;
            logic [7:0]  opcode;
        } reg_fmt;
        struct packed {
            logic               typ;
            logic [1:0]         row;
            logic [1:0]         col;
            logic [2:0]         spare_hi;
            logic signed [15:0] value;
            logic [7:0]         spare_lo;
        } mat_fmt;
    } gl_inst_u;

endpackage

/* hdl/gl_if.sv */
`timescale 1ns/1ps

// decode to execute, four-phase req/ack
interface gl_cmd_if import gl_pkg::*; (input logic clk1, input logic reset);
    logic               req;
    logic               ack;
    gl_cmd_kind_e       kind;
    logic [1:0]         row;
    logic [1:0]         col;
    logic signed [15:0] value;
    logic signed [15:0] x;
    logic signed [15:0] y;
    logic [15:0]        color;
    logic signed [15:0] view_x;
    logic signed [15:0] view_y;

    modport sender (output req, kind, row, col, value, x, y, color, view_x, view_y,
                    input ack);
    modport receiver (input req, kind, row, col, value, x, y, color, view_x, view_y,
                      output ack);

    // payload frozen for the whole req phase
    assert property (@(posedge clk1) disable iff (reset)
        req |=> !req || $stable({kind, row, col, value, x, y, color, view_x, view_y}))
        else $error("gl_cmd_if payload changed under req");
    assert property (@(posedge clk1) disable iff (reset) req && !ack |=> req)
        else $error("gl_cmd_if req dropped before ack");
endinterface

// execute to result, same protocol
interface gl_vtx_if (input logic clk1, input logic reset);
    logic               req;
    logic               ack;
    logic               last;
    logic signed [31:0] tx;
    logic signed [31:0] ty;
    logic [15:0]        color;
    logic signed [15:0] view_x;
    logic signed [15:0] view_y;

    modport sender (output req, last, tx, ty, color, view_x, view_y, input ack);
    modport receiver (input req, last, tx, ty, color, view_x, view_y, output ack);

    assert property (@(posedge clk1) disable iff (reset)
        req |=> !req || $stable({last, tx, ty, color, view_x, view_y}))
        else $error("gl_vtx_if payload changed under req");
    assert property (@(posedge clk1) disable iff (reset) req && !ack |=> req)
        else $error("gl_vtx_if req dropped before ack");
endinterface

/* hdl/gl_inst_mem.sv */
`timescale 1ns/1ps
`include "gl_params.svh"

module gl_inst_mem (
    input  logic                  clk1,
    input  logic                  reset,
    input  logic                  busy,     // fetch is running
    input  logic                  we,
    input  logic [`GL_ADDR_W-1:0] waddr,
    input  logic [31:0]           wdata,
    input  logic [`GL_ADDR_W-1:0] raddr,
    output logic [31:0]           rdata
);

    logic [31:0] mem [`GL_PROG_DEPTH];

    ////////////////////
    // host write, fetch read
    ////////////////////

    always_ff @(posedge clk1)
    begin
        if (we)
        begin
            mem[waddr] <= wdata;
        end
        rdata <= mem[raddr];    // one cycle read latency
    end

    // program must not change under a running fetch
    assert property (@(posedge clk1) disable iff (reset) we |-> !busy)
        else $error("program written while fetch is busy");

endmodule

/* hdl/gl_fetch.sv */
`timescale 1ns/1ps
`include "gl_params.svh"

module gl_fetch import gl_pkg::*; (
    input  logic                  clk1,
    input  logic                  reset,
    input  logic                  start,
    input  logic                  done,
    input  logic                  stall,
    output logic                  busy,
    output logic [`GL_ADDR_W-1:0] raddr,
    input  logic [31:0]           rdata,
    output logic [31:0]           inst,
    output logic                  inst_valid
);

    logic [`GL_ADDR_W-1:0] pc;
    logic [`GL_ADDR_W-1:0] last_addr;   // address whose word sits in rdata
    logic                  running;     // still issuing addresses
    logic                  rd_valid;    // rdata holds a program word
    logic                  halt_word;

    // replay the held address so rdata survives a stall
    assign raddr = stall ? last_addr : pc;

    // register format with opcode FF
    assign halt_word = rd_valid && !rdata[31] && rdata[7:0] == OP_HALT;

    always_ff @(posedge clk1)
    begin
        if (reset)
        begin
            busy       <= 1'b0;
            running    <= 1'b0;
            rd_valid   <= 1'b0;
            inst_valid <= 1'b0;
            pc         <= '0;
        end
        else if (start && !busy)
        begin
            busy       <= 1'b1;
            running    <= 1'b1;
            rd_valid   <= 1'b0;
            inst_valid <= 1'b0;
            pc         <= '0;
        end
        else
        begin
            if (done)
                busy <= 1'b0;
            if (!stall)
            begin
                inst_valid <= rd_valid;
                if (halt_word)
                begin
                    running  <= 1'b0;   // drop the read in flight
                    rd_valid <= 1'b0;
                end
                else if (running)
                begin
                    pc       <= pc + 1'b1;
                    rd_valid <= 1'b1;
                end
                else
                    rd_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk1)
    begin
        last_addr <= raddr;
        if (!stall && rd_valid)
            inst <= rdata;
    end

endmodule

/* hdl/gl_decode.sv */
`timescale 1ns/1ps

module gl_decode import gl_pkg::*; (
    input  logic        clk1,
    input  logic        reset,
    input  logic [31:0] inst,
    input  logic        inst_valid,
    output logic        stall,
    gl_cmd_if.sender    cmd
);

    localparam logic [1:0] S_IDLE = 2'd0;
    localparam logic [1:0] S_REQ  = 2'd1;   // req high, waiting for ack
    localparam logic [1:0] S_DROP = 2'd2;   // req low, waiting for ack low

    gl_inst_u           word;
    gl_opcode_e         opcode;
    logic [1:0]         state;
    logic               is_mat;
    logic               is_cmd;
    logic signed [15:0] imm16;
    logic [15:0]        color_q;
    logic signed [15:0] view_x_q;
    logic signed [15:0] view_y_q;
    logic signed [15:0] pend_x;     // x waiting for VERTEX_Y

    assign word   = inst;
    assign is_mat = word.mat_fmt.typ;
    assign opcode = gl_opcode_e'(word.reg_fmt.opcode);
    assign imm16  = word.reg_fmt.imm[15:0];
    assign is_cmd = is_mat || opcode == OP_VERTEX_Y || opcode == OP_HALT;

    ////////////////////
    // command payload
    ////////////////////

    // inst holds during stall, so these stay put under req
    always_comb
    begin
        if (is_mat)
            cmd.kind = CMD_LOAD;
        else if (opcode == OP_HALT)
            cmd.kind = CMD_HALT;
        else
            cmd.kind = CMD_VERTEX;
    end

    assign cmd.row    = word.mat_fmt.row;
    assign cmd.col    = word.mat_fmt.col;
    assign cmd.value  = word.mat_fmt.value;
    assign cmd.x      = pend_x;
    assign cmd.y      = imm16;
    assign cmd.color  = color_q;
    assign cmd.view_x = view_x_q;
    assign cmd.view_y = view_y_q;

    // released in the cycle ack is seen low again
    always_comb
    begin
        case (state)
            S_IDLE:  stall = inst_valid && is_cmd;
            S_REQ:   stall = 1'b1;
            default: stall = cmd.ack;
        endcase
    end

    always_ff @(posedge clk1)
    begin
        if (reset)
        begin
            state    <= S_IDLE;
            cmd.req  <= 1'b0;
            color_q  <= '0;
            view_x_q <= '0;
            view_y_q <= '0;
            pend_x   <= '0;
        end
        else
        begin
            case (state)
                S_IDLE:
                    if (inst_valid && is_cmd)
                    begin
                        cmd.req <= 1'b1;
                        state   <= S_REQ;
                    end
                    else if (inst_valid)
                    begin
                        case (opcode)   // absorbed in one cycle
                            OP_SET_COLOR:  color_q  <= word.reg_fmt.imm[15:0];
                            OP_SET_VIEW_X: view_x_q <= imm16;
                            OP_SET_VIEW_Y: view_y_q <= imm16;
                            OP_VERTEX_X:   pend_x   <= imm16;
                            default: ;
                        endcase
                    end
                S_REQ:
                    if (cmd.ack)
                    begin
                        cmd.req <= 1'b0;
                        state   <= S_DROP;
                    end
                default:
                    if (!cmd.ack)
                        state <= S_IDLE;
            endcase
        end
    end

    // fetch must freeze its output while decode stalls
    assert property (@(posedge clk1) disable iff (reset) stall |=> !$rose(inst_valid))
        else $error("new instruction presented during stall");

endmodule

/* hdl/gl_execute.sv */
`timescale 1ns/1ps

module gl_execute import gl_pkg::*; (
    input  logic       clk1,
    input  logic       reset,
    gl_cmd_if.receiver cmd,
    gl_vtx_if.sender   vtx
);

    logic signed [15:0] m [2][3];       // 2x3 affine matrix, column 2 is translation
    logic signed [15:0] x_q;
    logic signed [15:0] y_q;
    logic signed [31:0] prod [2][2];
    logic signed [31:0] sum [2];
    logic               p0_valid;       // x_q and y_q loaded
    logic               p1_valid;       // products loaded
    logic               accept;

    // one command at a time, vertex path must be empty
    assign accept = cmd.req && !cmd.ack && !p0_valid && !p1_valid && !vtx.req && !vtx.ack;

    ////////////////////
    // control and matrix
    ////////////////////

    always_ff @(posedge clk1)
    begin
        if (reset)
        begin
            cmd.ack  <= 1'b0;
            vtx.req  <= 1'b0;
            vtx.last <= 1'b0;
            p0_valid <= 1'b0;
            p1_valid <= 1'b0;
            for (int r = 0; r < 2; r++)
            begin
                for (int c = 0; c < 3; c++)
                begin
                    m[r][c] <= (r == c) ? 16'sd1 : 16'sd0;  // identity
                end
            end
        end
        else
        begin
            p0_valid <= 1'b0;
            p1_valid <= p0_valid;
            if (accept)
            begin
                cmd.ack  <= 1'b1;
                vtx.last <= (cmd.kind == CMD_HALT);
                case (cmd.kind)
                    CMD_LOAD:
                        if (cmd.row < 2'd2 && cmd.col < 2'd3)   // else dropped, still acked
                            m[cmd.row[0]][cmd.col] <= cmd.value;
                    CMD_VERTEX: p0_valid <= 1'b1;
                    CMD_HALT:   vtx.req  <= 1'b1;   // marker skips the datapath
                    default: ;
                endcase
            end
            else if (cmd.ack && !cmd.req)
                cmd.ack <= 1'b0;

            if (p1_valid)
                vtx.req <= 1'b1;    // sums land on this edge too
            else if (vtx.req && vtx.ack)
                vtx.req <= 1'b0;
        end
    end

    ////////////////////
    // transform datapath
    ////////////////////

    always_ff @(posedge clk1)
    begin
        if (accept)
        begin
            x_q        <= cmd.x;
            y_q        <= cmd.y;
            vtx.color  <= cmd.color;
            vtx.view_x <= cmd.view_x;
            vtx.view_y <= cmd.view_y;
        end
        for (int r = 0; r < 2; r++)
        begin
            if (p0_valid)
            begin
                prod[r][0] <= m[r][0] * x_q;    // signed 16x16
                prod[r][1] <= m[r][1] * y_q;
            end
            if (p1_valid)
                sum[r] <= prod[r][0] + prod[r][1] + m[r][2];   // wraps at 32 bits
        end
    end

    assign vtx.tx = sum[0];
    assign vtx.ty = sum[1];

endmodule

/* hdl/gl_result.sv */
`timescale 1ns/1ps

module gl_result (
    input  logic               clk1,
    input  logic               reset,
    gl_vtx_if.receiver         vtx,
    output logic               out_req,
    input  logic               out_ack,
    output logic signed [31:0] out_x,
    output logic signed [31:0] out_y,
    output logic [15:0]        out_color,
    output logic               done
);

    localparam logic [1:0] R_IDLE = 2'd0;
    localparam logic [1:0] R_OUT  = 2'd1;   // out_req high
    localparam logic [1:0] R_WAIT = 2'd2;   // host dropping out_ack
    localparam logic [1:0] R_ACK  = 2'd3;   // vtx ack high

    logic [1:0] state;

    ////////////////////
    // host handshake
    ////////////////////

    // vtx ack waits for the whole host cycle
    always_ff @(posedge clk1)
    begin
        if (reset)
        begin
            state   <= R_IDLE;
            out_req <= 1'b0;
            vtx.ack <= 1'b0;
            done    <= 1'b0;
        end
        else
        begin
            done <= 1'b0;
            case (state)
                R_IDLE:
                    if (vtx.req)
                    begin
                        if (vtx.last)
                        begin
                            done    <= 1'b1;    // end of program, no output
                            vtx.ack <= 1'b1;
                            state   <= R_ACK;
                        end
                        else
                        begin
                            out_req <= 1'b1;
                            state   <= R_OUT;
                        end
                    end
                R_OUT:
                    if (out_ack)
                    begin
                        out_req <= 1'b0;
                        state   <= R_WAIT;
                    end
                R_WAIT:
                    if (!out_ack)
                    begin
                        vtx.ack <= 1'b1;
                        state   <= R_ACK;
                    end
                default:
                    if (!vtx.req)
                    begin
                        vtx.ack <= 1'b0;
                        state   <= R_IDLE;
                    end
            endcase
        end
    end

    // viewport offset added on capture, held until the next item
    always_ff @(posedge clk1)
    begin
        if (state == R_IDLE && vtx.req && !vtx.last)
        begin
            out_x     <= vtx.tx + vtx.view_x;
            out_y     <= vtx.ty + vtx.view_y;
            out_color <= vtx.color;
        end
    end

    assert property (@(posedge clk1) disable iff (reset) $rose(out_ack) |-> out_req)
        else $error("out_ack raised without out_req");

endmodule

/* hdl/gl_geometry_core.sv */
`timescale 1ns/1ps
`include "gl_params.svh"

module gl_geometry_core (
    input  logic                  clk1,
    input  logic                  reset,
    input  logic                  prog_we,
    input  logic [`GL_ADDR_W-1:0] prog_addr,
    input  logic [31:0]           prog_data,
    input  logic                  start,
    output logic                  busy,
    output logic                  out_req,
    input  logic                  out_ack,
    output logic signed [31:0]    out_x,
    output logic signed [31:0]    out_y,
    output logic [15:0]           out_color
);

    logic [`GL_ADDR_W-1:0] raddr;
    logic [31:0]           rdata;
    logic [31:0]           inst;
    logic                  inst_valid;
    logic                  stall;
    logic                  done;    // result saw the halt marker

    gl_cmd_if cmd_bus (.clk1(clk1), .reset(reset));
    gl_vtx_if vtx_bus (.clk1(clk1), .reset(reset));

    gl_inst_mem u_inst_mem (
        .clk1  (clk1),
        .reset (reset),
        .busy  (busy),
        .we    (prog_we),
        .waddr (prog_addr),
        .wdata (prog_data),
        .raddr (raddr),
        .rdata (rdata)
    );

    gl_fetch u_fetch (
        .clk1       (clk1),
        .reset      (reset),
        .start      (start),
        .done       (done),
        .stall      (stall),
        .busy       (busy),
        .raddr      (raddr),
        .rdata      (rdata),
        .inst       (inst),
        .inst_valid (inst_valid)
    );

    gl_decode u_decode (
        .clk1       (clk1),
        .reset      (reset),
        .inst       (inst),
        .inst_valid (inst_valid),
        .stall      (stall),
        .cmd        (cmd_bus.sender)
    );

    gl_execute u_execute (
        .clk1  (clk1),
        .reset (reset),
        .cmd   (cmd_bus.receiver),
        .vtx   (vtx_bus.sender)
    );

    gl_result u_result (
        .clk1      (clk1),
        .reset     (reset),
        .vtx       (vtx_bus.receiver),
        .out_req   (out_req),
        .out_ack   (out_ack),
        .out_x     (out_x),
        .out_y     (out_y),
        .out_color (out_color),
        .done      (done)
    );

endmodule

/* sim/tb_gl_geometry_core.sv */
`timescale 1ns/1ps
`include "gl_params.svh"

module tb_gl_geometry_core import gl_pkg::*; ();

    localparam int NUM_TESTS       = 6;
    localparam int CYCLES_PER_TEST = 2000;

    logic                  clk1 = 1'b0;
    logic                  reset;
    logic                  prog_we;
    logic [`GL_ADDR_W-1:0] prog_addr;
    logic [31:0]           prog_data;
    logic                  start;
    logic                  busy;
    logic                  out_req;
    logic                  out_ack;
    logic signed [31:0]    out_x;
    logic signed [31:0]    out_y;
    logic [15:0]           out_color;

    logic [31:0]        prog [$];      // program image being built
    logic signed [31:0] exp_x [$];
    logic signed [31:0] exp_y [$];
    logic [15:0]        exp_c [$];

    // reference model state, mirrors the core between programs
    logic signed [31:0] mdl_m [2][3];
    logic [15:0]        mdl_color;
    logic signed [31:0] mdl_vx;
    logic signed [31:0] mdl_vy;
    logic signed [31:0] mdl_px;

    logic [31:0] lfsr_state = 32'h8e25;
    int          errors = 0;
    int          tests_run = 0;
    int          tests_failed = 0;
    int          outputs_seen = 0;
    int          err_start;
    string       cur_name;
    logic        ack_random;    // host delay from the LFSR
    int          ack_delay;

    always #10 clk1 = ~clk1;

    gl_geometry_core u_gl_geometry_core (
        .clk1      (clk1),
        .reset     (reset),
        .prog_we   (prog_we),
        .prog_addr (prog_addr),
        .prog_data (prog_data),
        .start     (start),
        .busy      (busy),
        .out_req   (out_req),
        .out_ack   (out_ack),
        .out_x     (out_x),
        .out_y     (out_y),
        .out_color (out_color)
    );

    ////////////////////
    // random bits and encoding
    ////////////////////

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic lfsr_step();
        logic fb;
        fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
        lfsr_state = {lfsr_state[30:0], fb};
        return fb;
    endfunction

    function automatic logic [15:0] rand_bits(input int n);
        logic [15:0] v;
        v = '0;
        for (int i = 0; i < n; i++)
            v = {v[14:0], lfsr_step()};    // one step per bit
        return v;
    endfunction

    function automatic logic signed [31:0] sext16(input logic [15:0] v);
        return {{16{v[15]}}, v};
    endfunction

    function automatic gl_inst_u encode_reg(input logic [7:0] op, input logic [15:0] imm);
        gl_inst_u w;
        w = '0;
        w.reg_fmt.typ    = 1'b0;
        w.reg_fmt.imm    = {7'd0, imm};
        w.reg_fmt.opcode = op;
        return w;
    endfunction

    function automatic gl_inst_u encode_mat(input logic [1:0] row, input logic [1:0] col,
                                            input logic [15:0] val);
        gl_inst_u w;
        w = '0;
        w.mat_fmt.typ   = 1'b1;
        w.mat_fmt.row   = row;
        w.mat_fmt.col   = col;
        w.mat_fmt.value = val;
        return w;
    endfunction

    ////////////////////
    // program builder and model
    ////////////////////

    function automatic void model_reset();
        for (int r = 0; r < 2; r++)
            for (int c = 0; c < 3; c++)
                mdl_m[r][c] = (r == c) ? 32'sd1 : 32'sd0;
        mdl_color = '0;
        mdl_vx    = '0;
        mdl_vy    = '0;
        mdl_px    = '0;
    endfunction

    function automatic void emit_load(input logic [1:0] row, input logic [1:0] col,
                                      input logic [15:0] val);
        prog.push_back(encode_mat(row, col, val));
        if (row < 2'd2 && col < 2'd3)      // out of range is dropped
            mdl_m[row[0]][col] = sext16(val);
    endfunction

    function automatic void emit_color(input logic [15:0] c);
        prog.push_back(encode_reg(OP_SET_COLOR, c));
        mdl_color = c;
    endfunction

    function automatic void emit_view(input logic [15:0] vx, input logic [15:0] vy);
        prog.push_back(encode_reg(OP_SET_VIEW_X, vx));
        prog.push_back(encode_reg(OP_SET_VIEW_Y, vy));
        mdl_vx = sext16(vx);
        mdl_vy = sext16(vy);
    endfunction

    function automatic void emit_vertex_x(input logic [15:0] x);
        prog.push_back(encode_reg(OP_VERTEX_X, x));
        mdl_px = sext16(x);
    endfunction

    // affine transform plus viewport, all wrapping at 32 bits
    function automatic void emit_vertex_y(input logic [15:0] y);
        logic signed [31:0] ys;
        logic signed [31:0] tx;
        logic signed [31:0] ty;
        ys = sext16(y);
        prog.push_back(encode_reg(OP_VERTEX_Y, y));
        tx = mdl_m[0][0] * mdl_px + mdl_m[0][1] * ys + mdl_m[0][2];
        ty = mdl_m[1][0] * mdl_px + mdl_m[1][1] * ys + mdl_m[1][2];
        exp_x.push_back(tx + mdl_vx);
        exp_y.push_back(ty + mdl_vy);
        exp_c.push_back(mdl_color);
    endfunction

    function automatic void emit_vertex(input logic [15:0] x, input logic [15:0] y);
        emit_vertex_x(x);
        emit_vertex_y(y);
    endfunction

    function automatic void emit_noop();
        prog.push_back(encode_reg(8'h42, 16'h0bad));
    endfunction

    function automatic void emit_halt();
        prog.push_back(encode_reg(OP_HALT, 16'h0000));
    endfunction

    ////////////////////
    // bus-side tasks
    ////////////////////

    task automatic next_cycle();    // drive point
        @(posedge clk1);
        #2;
    endtask

    task automatic wait_sample();   // host sample point
        @(posedge clk1);
        #1;
    endtask

    task automatic load_program();
        if (prog.size() > `GL_PROG_DEPTH)
        begin
            $display("program of %0d words does not fit the memory", prog.size());
            errors++;
        end
        for (int i = 0; i < prog.size(); i++)
        begin
            prog_we   = 1'b1;
            prog_addr = i[`GL_ADDR_W-1:0];
            prog_data = prog[i];
            next_cycle();
        end
        prog_we = 1'b0;
        prog.delete();
    endtask

    task automatic start_program();
        start = 1'b1;
        next_cycle();
        start = 1'b0;
        assert (busy)
        else
        begin
            $display("busy did not rise after start at %0t ns", $time);
            errors++;
        end
    endtask

    task automatic wait_idle();
        int n;
        n = 0;
        while (busy && n < CYCLES_PER_TEST - 200)
        begin
            next_cycle();
            n++;
        end
        assert (!busy)
        else
        begin
            $display("busy still high %0d cycles after start at %0t ns", n, $time);
            errors++;
        end
    endtask

    task automatic run_program();
        load_program();
        start_program();
        wait_idle();
    endtask

    function automatic void check_output(input logic signed [31:0] x,
                                         input logic signed [31:0] y,
                                         input logic [15:0] c);
        logic signed [31:0] ex;
        logic signed [31:0] ey;
        logic [15:0]        ec;
        outputs_seen++;
        if (exp_x.size() == 0)
        begin
            $display("unexpected output (%0d, %0d) at %0t ns", x, y, $time);
            errors++;
        end
        else
        begin
            ex = exp_x.pop_front();
            ey = exp_y.pop_front();
            ec = exp_c.pop_front();
            assert (x == ex && y == ey && c == ec)
            else
            begin
                $display("** Error at %0t ns: got (%0d, %0d, %h) expected (%0d, %0d, %h)",
                         $time, x, y, c, ex, ey, ec);
                errors++;
            end
        end
    endfunction

    function automatic void check_held(input logic signed [31:0] x0,
                                       input logic signed [31:0] y0,
                                       input logic [15:0] c0);
        assert (out_req && out_x == x0 && out_y == y0 && out_color == c0)
        else
        begin
            $display("** Error at %0t ns: output moved or out_req fell before out_ack", $time);
            errors++;
        end
    endfunction

    // one host cycle, gives up when reset shows up
    task automatic respond(input int delay);
        logic signed [31:0] x0;
        logic signed [31:0] y0;
        logic [15:0]        c0;
        int                 n;
        x0 = out_x;
        y0 = out_y;
        c0 = out_color;
        check_output(x0, y0, c0);
        n = 0;
        while (n < delay && !reset)
        begin
            wait_sample();
            if (!reset)
                check_held(x0, y0, c0);
            n++;
        end
        if (!reset)
        begin
            #1 out_ack = 1'b1;
            do
            begin
                wait_sample();
                if (!reset && out_req)
                    check_held(x0, y0, c0);
            end
            while (out_req && !reset);
        end
        #1 out_ack = 1'b0;
    endtask

    initial
    begin : host_side
        int delay;
        out_ack = 1'b0;
        forever
        begin
            wait_sample();
            if (!reset && out_req)
            begin
                delay = ack_random ? int'(rand_bits(4)) : ack_delay;
                respond(delay);
            end
        end
    end

    ////////////////////
    // directed tests
    ////////////////////

    task automatic begin_test(input string name);
        cur_name  = name;
        err_start = errors;
    endtask

    task automatic end_test();
        assert (exp_x.size() == 0)
        else
        begin
            $display("%0d expected outputs never arrived", exp_x.size());
            errors++;
        end
        exp_x.delete();
        exp_y.delete();
        exp_c.delete();
        tests_run++;
        if (errors != err_start)
            tests_failed++;
        $display("test %-18s %s (%0d errors)", cur_name,
                 (errors == err_start) ? "ok" : "FAILED", errors - err_start);
    endtask

    task automatic identity_after_reset();
        begin_test("identity");
        emit_color(16'h1234);
        emit_view(16'sd100, -16'sd50);
        emit_vertex(16'sd10, 16'sd20);
        emit_vertex(-16'sd7, 16'sd300);
        emit_vertex(16'sd32767, 16'h8000);
        emit_halt();
        run_program();
        end_test();
    endtask

    task automatic matrix_load();
        begin_test("matrix load");
        emit_load(2'd0, 2'd0, 16'sd3);
        emit_load(2'd0, 2'd1, -16'sd2);
        emit_load(2'd0, 2'd2, 16'sd1000);
        emit_load(2'd1, 2'd0, -16'sd7);
        emit_load(2'd1, 2'd1, 16'sd5);
        emit_load(2'd1, 2'd2, -16'sd300);
        emit_vertex(16'sd4, 16'sd9);
        emit_vertex(-16'sd100, 16'sd250);
        emit_load(2'd2, 2'd0, 16'sd99);     // none of these land
        emit_load(2'd0, 2'd3, 16'sd77);
        emit_load(2'd3, 2'd3, 16'sd55);
        emit_vertex(16'sd1, 16'sd1);
        emit_load(2'd0, 2'd0, 16'h8000);
        emit_load(2'd0, 2'd1, 16'h8000);
        emit_vertex(16'h8000, 16'h8000);    // 2^31 wraps negative
        emit_halt();
        run_program();
        end_test();
    endtask

    task automatic slow_host();
        logic [15:0] a;
        logic [15:0] b;
        begin_test("back-pressure");
        ack_random = 1'b1;
        for (int i = 0; i < 8; i++)
        begin
            a = rand_bits(16);
            b = rand_bits(16);
            emit_vertex(a, b);
        end
        emit_halt();
        run_program();
        ack_random = 1'b0;
        end_test();
    endtask

    task automatic random_programs();
        logic [15:0] sel;
        logic [15:0] a;
        logic [15:0] b;
        begin_test("random programs");
        ack_delay = 2;
        for (int p = 0; p < 2; p++)
        begin
            for (int i = 0; i < 20; i++)
            begin
                sel = rand_bits(3);
                a   = rand_bits(16);
                b   = rand_bits(16);
                case (sel[2:0])
                    3'd0, 3'd1: emit_load(a[1:0], a[3:2], b);
                    3'd2:       emit_color(b);
                    3'd3:       emit_view(a, b);
                    3'd4:       emit_noop();
                    3'd5:       emit_vertex_y(b);   // reuses the pending x
                    default:    emit_vertex(a, b);
                endcase
            end
            emit_halt();
            run_program();
        end
        ack_delay = 0;
        end_test();
    endtask

    task automatic config_only();
        int seen;
        begin_test("no vertices");
        seen = outputs_seen;
        emit_color(16'hbeef);
        emit_view(16'sd5, 16'sd6);
        emit_load(2'd1, 2'd1, 16'sd4);
        emit_vertex_x(16'sd9);
        emit_noop();
        emit_halt();
        run_program();
        assert (outputs_seen == seen)
        else
        begin
            $display("out_req rose in a program with no vertices");
            errors++;
        end
        end_test();
    endtask

    task automatic reset_mid_program();
        begin_test("reset mid-run");
        ack_delay = 6;
        emit_load(2'd0, 2'd0, 16'sd2);
        emit_load(2'd1, 2'd2, 16'sd55);
        for (int i = 0; i < 10; i++)
            emit_vertex(16'(i * 3), 16'(-i));
        emit_halt();
        load_program();
        start_program();
        repeat (40) next_cycle();
        reset = 1'b1;
        repeat (4)
        begin
            next_cycle();
            assert (!busy && !out_req)
            else
            begin
                $display("** Error at %0t ns: busy or out_req high under reset", $time);
                errors++;
            end
        end
        reset = 1'b0;
        exp_x.delete();     // the cut-off program is gone
        exp_y.delete();
        exp_c.delete();
        model_reset();
        ack_delay = 0;
        next_cycle();
        // color and viewport left at their reset values
        emit_vertex(16'sd11, -16'sd22);
        emit_vertex(-16'sd300, 16'sd400);
        emit_halt();
        run_program();
        end_test();
    endtask

    ////////////////////
    // main sequence
    ////////////////////

    initial
    begin
        reset      = 1'b1;
        prog_we    = 1'b0;
        prog_addr  = '0;
        prog_data  = '0;
        start      = 1'b0;
        ack_random = 1'b0;
        ack_delay  = 0;
        model_reset();
        repeat (16) @(posedge clk1);
        #2 reset = 1'b0;

        identity_after_reset();
        matrix_load();
        slow_host();
        random_programs();
        config_only();
        reset_mid_program();

        $display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0)
            $display("Done: no errors");
        else
            $display("Done: errors found");
        $finish;
    end

    initial
    begin : watchdog
        repeat (NUM_TESTS * CYCLES_PER_TEST) @(posedge clk1);
        $display("watchdog expired after %0d cycles, tests did not complete",
                 NUM_TESTS * CYCLES_PER_TEST);
        $display("Done: errors found");
        $finish;
    end

endmodule

/* files.f */
+incdir+hdl
hdl/gl_pkg.sv
hdl/gl_if.sv
hdl/gl_inst_mem.sv
hdl/gl_fetch.sv
hdl/gl_decode.sv
hdl/gl_execute.sv
hdl/gl_result.sv
hdl/gl_geometry_core.sv
sim/tb_gl_geometry_core.sv

/* Makefile */
TOP := tb_gl_geometry_core

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check sim.log"
	@echo "  clean  remove obj_dir and sim.log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal -f files.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) > sim.log 2>&1 || echo "Done: errors found" >> sim.log
	@cat sim.log
	@if grep -q "Done: errors found" sim.log; then echo "FAIL"; exit 1; fi
	@echo "PASS"

clean:
	rm -rf obj_dir sim.log
